/* arb_hub.f */
verilog/arb_cfg_pkg.sv
verilog/arb_cmd_pkg.sv
verilog/cmd_fifo.sv
verilog/matrix_arbiter.sv
verilog/grant_mux.sv
verilog/arb_hub.sv
dv/matrix_arbiter_asserts.sv
dv/arb_hub_checker.sv
dv/arb_hub_tb.sv

/* Bender.yml */
package:
  name: arb_hub

sources:
  # synthesizable design
  - files:
      - verilog/arb_cfg_pkg.sv
      - verilog/arb_cmd_pkg.sv
      - verilog/cmd_fifo.sv
      - verilog/matrix_arbiter.sv
      - verilog/grant_mux.sv
      - verilog/arb_hub.sv

  # verification only
  - target: simulation
    files:
      - dv/matrix_arbiter_asserts.sv
      - dv/arb_hub_checker.sv
      - dv/arb_hub_tb.sv

/* dv/arb_hub_tb.sv */
`timescale 1ns/1ps

module arb_hub_tb;

  localparam int NUM_PORTS   = arb_cfg_pkg::DEF_NUM_PORTS;
  localparam int FIFO_DEPTH  = arb_cfg_pkg::DEF_FIFO_DEPTH;
  localparam int AW          = arb_cfg_pkg::ADDR_W;
  localparam int DW          = arb_cfg_pkg::DATA_W;
  localparam int FULL_PORT   = NUM_PORTS - 1;
  localparam int DRAIN_LIMIT = 200;

  logic                              clk;
  logic                              reset;
  logic [NUM_PORTS-1:0]              cmd_valid;
  arb_cmd_pkg::cmd_t [NUM_PORTS-1:0] cmd_in;
  logic [NUM_PORTS-1:0]              full;
  logic                              out_valid;
  arb_cmd_pkg::cmd_t                 out_cmd;
  logic [NUM_PORTS-1:0]              out_grant;
  logic                              rotation_check;
  logic                              idle;
  int                                err_count;
  int                                drop_count;
  int                                tests_run;
  int                                tests_failed;
  int                                err_at_start;
  int                                drops_at_start;
  int                                asserts_at_start;
  logic                              test_bad;
  string                             test_name;

  arb_hub UUT (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_cmd_valid (cmd_valid),
    .i_cmd       (cmd_in),
    .o_full      (full),
    .o_valid     (out_valid),
    .o_cmd       (out_cmd),
    .o_grant     (out_grant)
  );

  arb_hub_checker #(
    .NUM_PORTS  (NUM_PORTS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_checker (
    .i_clk            (clk),
    .i_reset          (reset),
    .i_cmd_valid      (cmd_valid),
    .i_cmd            (cmd_in),
    .i_full           (full),
    .i_valid          (out_valid),
    .i_out_cmd        (out_cmd),
    .i_grant          (out_grant),
    .i_rotation_check (rotation_check),
    .o_idle           (idle),
    .o_err_count      (err_count),
    .o_drop_count     (drop_count)
  );

  always #10 clk = ~clk;

  function automatic arb_cmd_pkg::cmd_t random_cmd();
    arb_cmd_pkg::cmd_t c;
    c.write = 1'($urandom);
    c.addr  = AW'($urandom);
    c.data  = DW'($urandom);
    return c;
  endfunction

  function automatic logic [NUM_PORTS-1:0] random_mask();
    logic [NUM_PORTS-1:0] m;
    for (int p = 0; p < NUM_PORTS; p++) begin
      m[p] = (($urandom % 3) == 0);
    end
    return m;
  endfunction

  // one cycle of strobes, fresh commands on every port
  task automatic strobe_ports(input logic [NUM_PORTS-1:0] mask);
    arb_cmd_pkg::cmd_t [NUM_PORTS-1:0] next_cmds;
    for (int p = 0; p < NUM_PORTS; p++) begin
      next_cmds[p] = random_cmd();
    end
    @(posedge clk);
    cmd_valid <= mask;
    cmd_in    <= next_cmds;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset     <= 1'b1;
    cmd_valid <= '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name           = name;
    u_checker.test_name = name;
    err_at_start        = err_count;
    drops_at_start      = drop_count;
    asserts_at_start    = UUT.u_arbiter.u_asserts.fail_count;
    test_bad            = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (!idle && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!idle) begin
      $display("%s: outputs did not drain within %0d cycles", test_name, DRAIN_LIMIT);
      test_bad = 1'b1;
    end
  endtask

  task automatic end_test();
    if (err_count != err_at_start) begin
      test_bad = 1'b1;
    end
    if (UUT.u_arbiter.u_asserts.fail_count != asserts_at_start) begin
      test_bad = 1'b1;
    end
    tests_run++;
    if (test_bad) begin
      tests_failed++;
    end
    $display("%-12s %s, %0d mismatches", test_name, test_bad ? "failed" : "passed",
             err_count - err_at_start);
  endtask

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    cmd_valid      = '0;
    cmd_in         = '0;
    rotation_check = 1'b0;
    tests_run      = 0;
    tests_failed   = 0;
    void'($urandom(32'h6db2326a));

    // reset values, then a lone command on port 2
    begin_test("reset_state");
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    strobe_ports(NUM_PORTS'(1) << 2);
    strobe_ports('0);
    wait_drain();
    end_test();

    begin_test("fixed_order");
    apply_reset();
    strobe_ports('1);
    strobe_ports('0);
    wait_drain();
    end_test();

    begin_test("rotation");
    @(posedge clk);
    rotation_check <= 1'b1;
    repeat (40) strobe_ports('1);
    strobe_ports('0);
    rotation_check <= 1'b0;
    wait_drain();
    end_test();

    begin_test("random");
    repeat (400) strobe_ports(random_mask());
    strobe_ports('0);
    wait_drain();
    end_test();

    // a lone grant sends the last port to the bottom, then it gets swamped
    begin_test("full_drop");
    strobe_ports(NUM_PORTS'(1) << FULL_PORT);
    strobe_ports('0);
    wait_drain();
    repeat (FIFO_DEPTH + 2) strobe_ports('1);
    strobe_ports('0);
    wait_drain();
    if (drop_count == drops_at_start) begin
      $display("%s: no command was dropped at a full queue", test_name);
      test_bad = 1'b1;
    end
    end_test();

    $display("%0d tests, %0d failed, %0d mismatches, %0d drops, %0d assertion failures",
             tests_run, tests_failed, err_count, drop_count,
             UUT.u_arbiter.u_asserts.fail_count);
    if (tests_failed == 0 && err_count == 0 && UUT.u_arbiter.u_asserts.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* dv/arb_hub_checker.sv */
`timescale 1ns/1ps

module arb_hub_checker #(
  parameter int NUM_PORTS  = 4,
  parameter int FIFO_DEPTH = 4
)(
  input  var logic                              i_clk,
  input  var logic                              i_reset,
  input  var logic [NUM_PORTS-1:0]              i_cmd_valid,
  input  var arb_cmd_pkg::cmd_t [NUM_PORTS-1:0] i_cmd,
  input  var logic [NUM_PORTS-1:0]              i_full,
  input  var logic                              i_valid,
  input  var arb_cmd_pkg::cmd_t                 i_out_cmd,
  input  var logic [NUM_PORTS-1:0]              i_grant,
  input  var logic                              i_rotation_check,
  output logic                                  o_idle,
  output int                                    o_err_count,
  output int                                    o_drop_count
);

  typedef logic [NUM_PORTS-1:0][NUM_PORTS-1:0] matrix_t;

  string                test_name;
  arb_cmd_pkg::cmd_t    model_q [NUM_PORTS][FIFO_DEPTH];
  int                   model_cnt [NUM_PORTS];
  matrix_t              model_matrix;
  logic                 exp_valid;
  logic [NUM_PORTS-1:0] exp_grant;
  arb_cmd_pkg::cmd_t    exp_cmd;
  logic                 armed;
  logic [NUM_PORTS-1:0] grant_hist [NUM_PORTS];
  int                   hist_n;

  initial begin
    test_name    = "none";
    armed        = 1'b0;
    o_idle       = 1'b0;
    o_err_count  = 0;
    o_drop_count = 0;
    hist_n       = 0;
  end

  // port i wins when it requests and no other requester beats it
  function automatic logic [NUM_PORTS-1:0] ref_grant(input logic [NUM_PORTS-1:0] req,
                                                     input matrix_t m);
    logic [NUM_PORTS-1:0] g;
    g = req;
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int j = 0; j < NUM_PORTS; j++) begin
        if (j != i && req[j] && m[j][i]) begin
          g[i] = 1'b0;
        end
      end
    end
    return g;
  endfunction

  // the winner loses to everyone afterwards
  function automatic matrix_t ref_update(input matrix_t m, input logic [NUM_PORTS-1:0] g);
    matrix_t r;
    r = m;
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int j = 0; j < NUM_PORTS; j++) begin
        if (g[i] && j != i) begin
          r[i][j] = 1'b0;
          r[j][i] = 1'b1;
        end
      end
    end
    return r;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < NUM_PORTS; i++) begin
      model_cnt[i] = 0;
      for (int j = 0; j < NUM_PORTS; j++) begin
        model_matrix[i][j] = (i < j);
      end
    end
    exp_valid = 1'b0;
    exp_grant = '0;
    exp_cmd   = '0;
    hist_n    = 0;
  endtask

  task automatic report_value(input string what, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
    $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp_v, act_v);
    o_err_count++;
  endtask

  task automatic compare_outputs();
    logic [NUM_PORTS-1:0] full_exp;
    for (int p = 0; p < NUM_PORTS; p++) begin
      full_exp[p] = (model_cnt[p] == FIFO_DEPTH);
    end
    if (i_valid !== exp_valid) begin
      report_value("o_valid", 64'(exp_valid), 64'(i_valid));
    end
    if (i_grant !== exp_grant) begin
      report_value("o_grant", 64'(exp_grant), 64'(i_grant));
    end
    if (exp_valid && (i_out_cmd !== exp_cmd)) begin
      report_value("o_cmd", 64'(exp_cmd), 64'(i_out_cmd));
    end
    if (i_full !== full_exp) begin
      report_value("o_full", 64'(full_exp), 64'(i_full));
    end
  endtask

  // under saturation no port may repeat within NUM_PORTS outputs
  task automatic check_rotation();
    if (!i_rotation_check) begin
      hist_n = 0;
    end else if (i_valid) begin
      for (int k = 0; k < NUM_PORTS - 1; k++) begin
        if (k < hist_n && grant_hist[k] == i_grant) begin
          $display("%s: port granted twice within %0d outputs, grant %b",
                   test_name, NUM_PORTS, i_grant);
          o_err_count++;
        end
      end
      for (int k = NUM_PORTS - 1; k > 0; k--) begin
        grant_hist[k] = grant_hist[k-1];
      end
      grant_hist[0] = i_grant;
      hist_n++;
    end
  endtask

  // grant from the mirrored queues, pop before push so a full queue can refill
  task automatic step_model();
    logic [NUM_PORTS-1:0] req;
    logic [NUM_PORTS-1:0] g;
    for (int p = 0; p < NUM_PORTS; p++) begin
      req[p] = (model_cnt[p] != 0);
    end
    g = ref_grant(req, model_matrix);
    exp_valid = (g != '0);
    exp_grant = g;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (g[p]) begin
        exp_cmd = model_q[p][0];
        for (int k = 0; k < FIFO_DEPTH - 1; k++) begin
          model_q[p][k] = model_q[p][k+1];
        end
        model_cnt[p]--;
      end
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (i_cmd_valid[p]) begin
        if (model_cnt[p] < FIFO_DEPTH) begin
          model_q[p][model_cnt[p]] = i_cmd[p];
          model_cnt[p]++;
        end else begin
          o_drop_count++;
        end
      end
    end
    if (g != '0) begin
      model_matrix = ref_update(model_matrix, g);
    end
  endtask

  // sampled mid-cycle, away from the edge where inputs and outputs move
  always @(negedge i_clk) begin
    if (i_reset) begin
      reset_model();
      armed = 1'b1;
    end else if (armed) begin
      compare_outputs();
      check_rotation();
      step_model();
    end
    o_idle = armed && !exp_valid;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (model_cnt[p] != 0) begin
        o_idle = 1'b0;
      end
    end
  end

endmodule

/* dv/matrix_arbiter_asserts.sv */
`timescale 1ns/1ps

module matrix_arbiter_asserts #(
  parameter int NUM_PORTS = 4
)(
  input  var logic                                i_clk,
  input  var logic                                i_reset,
  input  var logic [NUM_PORTS-1:0]                i_request,
  input  var logic [NUM_PORTS-1:0]                i_grant,
  input  var logic [NUM_PORTS-1:0][NUM_PORTS-1:0] i_matrix
);

  int   row_count [NUM_PORTS];
  int   col_count [NUM_PORTS];
  logic rows_unique;
  logic cols_unique;
  logic grant_wins;
  int   fail_count;

  // in a total order every port beats a different number of others
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      row_count[i] = 0;
      col_count[i] = 0;
    end
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int j = 0; j < NUM_PORTS; j++) begin
        row_count[i] += int'(i_matrix[i][j]);
        col_count[j] += int'(i_matrix[i][j]);
      end
    end
    rows_unique = 1'b1;
    cols_unique = 1'b1;
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int j = i + 1; j < NUM_PORTS; j++) begin
        if (row_count[i] == row_count[j]) begin
          rows_unique = 1'b0;
        end
        if (col_count[i] == col_count[j]) begin
          cols_unique = 1'b0;
        end
      end
    end
  end

  // the granted port requests and beats every other active requester
  always_comb begin
    grant_wins = 1'b1;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (i_grant[i]) begin
        if (!i_request[i]) begin
          grant_wins = 1'b0;
        end
        for (int j = 0; j < NUM_PORTS; j++) begin
          if ((j != i) && i_request[j] && !i_matrix[i][j]) begin
            grant_wins = 1'b0;
          end
        end
      end
    end
  end

  a_rows_unique: assert property (@(posedge i_clk) disable iff (i_reset) rows_unique)
    else begin
      fail_count++;
      $error("priority matrix row counts are not unique");
    end

  a_cols_unique: assert property (@(posedge i_clk) disable iff (i_reset) cols_unique)
    else begin
      fail_count++;
      $error("priority matrix column counts are not unique");
    end

  a_grant_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_request != '0) |-> $onehot(i_grant))
    else begin
      fail_count++;
      $error("grant is not one-hot under an active request");
    end

  a_grant_requested: assert property (@(posedge i_clk) disable iff (i_reset) grant_wins)
    else begin
      fail_count++;
      $error("grant not on the highest priority active request");
    end

endmodule

bind matrix_arbiter matrix_arbiter_asserts #(
  .NUM_PORTS (NUM_PORTS)
) u_asserts (
  .i_clk     (i_clk),
  .i_reset   (i_reset),
  .i_request (i_request),
  .i_grant   (o_grant),
  .i_matrix  (priority_matrix)
);

/* verilog/arb_hub.sv */
`timescale 1ns/1ps

module arb_hub #(
  parameter int NUM_PORTS  = arb_cfg_pkg::DEF_NUM_PORTS,
  parameter int FIFO_DEPTH = arb_cfg_pkg::DEF_FIFO_DEPTH
)(
  input  var logic                              i_clk,
  input  var logic                              i_reset,
  input  var logic [NUM_PORTS-1:0]              i_cmd_valid,
  input  var arb_cmd_pkg::cmd_t [NUM_PORTS-1:0] i_cmd,
  output logic [NUM_PORTS-1:0]                  o_full,
  output logic                                  o_valid,
  output arb_cmd_pkg::cmd_t                     o_cmd,
  output logic [NUM_PORTS-1:0]                  o_grant
);

  logic [NUM_PORTS-1:0]              request;
  logic [NUM_PORTS-1:0]              grant;
  arb_cmd_pkg::cmd_t [NUM_PORTS-1:0] heads;

  // one queue per requester, popped by its own grant bit
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    cmd_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_push      (i_cmd_valid[p]),
      .i_data      (i_cmd[p]),
      .i_pop       (grant[p]),
      .o_head      (heads[p]),
      .o_not_empty (request[p]),
      .o_full      (o_full[p])
    );
  end

  matrix_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) u_arbiter (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_request (request),
    .o_grant   (grant)
  );

  grant_mux #(
    .NUM_PORTS (NUM_PORTS)
  ) u_mux (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_grant (grant),
    .i_heads (heads),
    .o_valid (o_valid),
    .o_cmd   (o_cmd),
    .o_grant (o_grant)
  );

endmodule

/* verilog/grant_mux.sv */
`timescale 1ns/1ps

module grant_mux #(
  parameter int NUM_PORTS = 4
)(
  input  var logic                                  i_clk,
  input  var logic                                  i_reset,
  input  var logic [NUM_PORTS-1:0]                  i_grant,
  input  var arb_cmd_pkg::cmd_t [NUM_PORTS-1:0]     i_heads,
  output logic                                      o_valid,
  output arb_cmd_pkg::cmd_t                         o_cmd,
  output logic [NUM_PORTS-1:0]                      o_grant
);

  logic [arb_cmd_pkg::CMD_W-1:0] sel_bits;

  // and-or select, grant is one-hot or zero
  always_comb begin
    sel_bits = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      sel_bits = sel_bits | (i_heads[p] & {arb_cmd_pkg::CMD_W{i_grant[p]}});
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
      o_grant <= '0;
    end else begin
      o_valid <= (i_grant != '0);
      o_grant <= i_grant;
    end
  end

  // payload only means something while o_valid is high
  always_ff @(posedge i_clk) begin
    o_cmd <= arb_cmd_pkg::cmd_t'(sel_bits);
  end

endmodule

/* verilog/matrix_arbiter.sv */
`timescale 1ns/1ps

module matrix_arbiter #(
  parameter int NUM_PORTS = 4
)(
  input  var logic                 i_clk,
  input  var logic                 i_reset,
  input  var logic [NUM_PORTS-1:0] i_request,
  output logic     [NUM_PORTS-1:0] o_grant
);

  // priority_matrix[i][j] set means port i beats port j
  // the diagonal stays clear, so row counts run 0 .. NUM_PORTS-1
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] priority_matrix;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] matrix_next;
  logic [NUM_PORTS-1:0]                blocked;

  // lower index wins out of reset
  function automatic logic [NUM_PORTS-1:0][NUM_PORTS-1:0] init_matrix();
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] m;
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int j = 0; j < NUM_PORTS; j++) begin
        m[i][j] = (i < j);
      end
    end
    return m;
  endfunction

  // a port loses when any other requester holds priority over it
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      blocked[i] = 1'b0;
      for (int j = 0; j < NUM_PORTS; j++) begin
        if ((j != i) && i_request[j] && priority_matrix[j][i]) begin
          blocked[i] = 1'b1;
        end
      end
    end
  end

  assign o_grant = i_request & ~blocked;

  // winner drops to lowest priority
  // clear its row, set its column apart from the diagonal
  always_comb begin
    matrix_next = priority_matrix;
    for (int g = 0; g < NUM_PORTS; g++) begin
      if (o_grant[g]) begin
        for (int j = 0; j < NUM_PORTS; j++) begin
          matrix_next[g][j] = 1'b0;
          if (j != g) begin
            matrix_next[j][g] = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      priority_matrix <= init_matrix();
    end else if (o_grant != '0) begin
      priority_matrix <= matrix_next;
    end
  end

endmodule

/* verilog/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int FIFO_DEPTH = 4
)(
  input  var logic               i_clk,
  input  var logic               i_reset,
  input  var logic               i_push,
  input  var arb_cmd_pkg::cmd_t  i_data,
  input  var logic               i_pop,
  output arb_cmd_pkg::cmd_t      o_head,
  output logic                   o_not_empty,
  output logic                   o_full
);

  // a single entry queue still needs a one bit pointer
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  arb_cmd_pkg::cmd_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push_ok;

  // a full queue still takes a push when its head leaves in the same cycle
  assign push_ok = i_push && (!o_full || i_pop);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge i_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_data;
    end
  end

  assign o_head      = mem[rd_ptr];
  assign o_not_empty = (count != '0);
  assign o_full      = (count == FULL_CNT);

endmodule

/* verilog/arb_cmd_pkg.sv */
// command types carried between the queues, the mux and the output
package arb_cmd_pkg;

  // one command as strobed in by a requester
  // write flag on top, then address, data in the low bits
  typedef struct packed {
    logic                          write;
    logic [arb_cfg_pkg::ADDR_W-1:0] addr;
    logic [arb_cfg_pkg::DATA_W-1:0] data;
  } cmd_t;

  // flat width of a command, 49 bits with the default sizes
  localparam int CMD_W = $bits(cmd_t);

endpackage

/* verilog/arb_cfg_pkg.sv */
// sizing of the arbiter hub and its command word
package arb_cfg_pkg;

  // command address width
  localparam int ADDR_W = 16;

  // command data width
  localparam int DATA_W = 32;

  // requesters on the hub, used as the top level default
  localparam int DEF_NUM_PORTS = 4;

  // entries in each per-port command queue
  localparam int DEF_FIFO_DEPTH = 4;

endpackage
